// File: hdl/bd_word_pkg.sv
package bd_word_pkg;

  // raw chunk coming up from the core
  localparam int nchunk = 20;

  // leaf code width, sits at the top of the decoded word
  localparam int nleaf = 5;

  // tag payload fields, msb first: global route, tag, count
  localparam int nglobal = 12;
  localparam int ntag = 11;
  localparam int nct = 9;
  localparam int npayload = nglobal + ntag + nct;

  // leaf codes of the upstream tree
  // only the two readout codes carry tags
  typedef enum logic [nleaf-1:0] {
    leaf_dump_pat       = 5'd0,
    leaf_dump_tat0      = 5'd1,
    leaf_dump_tat1      = 5'd2,
    leaf_dump_mm        = 5'd3,
    leaf_dump_am        = 5'd4,
    leaf_dump_prog_amm  = 5'd5,
    leaf_dump_pre_fifo  = 5'd6,
    leaf_dump_post_fifo = 5'd7,
    leaf_ovflw_pre      = 5'd8,
    leaf_ovflw_post     = 5'd9,
    leaf_nrn_spike      = 5'd10,
    leaf_ro_acc         = 5'd11,
    leaf_ro_tat         = 5'd12,
    leaf_dump_route     = 5'd13,
    leaf_dump_dac       = 5'd14,
    leaf_dump_adc       = 5'd15,
    leaf_delay_dump     = 5'd16,
    leaf_status         = 5'd17,
    leaf_unused         = 5'd31
  } leaf_code_t;

endpackage

// File: hdl/host_stream_pkg.sv
package host_stream_pkg;

  // host word payload, wide enough for leaf code plus decoded payload
  localparam int nhost_data = 40;

  // opcode sent with every host word
  typedef enum logic [1:0] {
    op_global_tag = 2'd0,
    op_tag        = 2'd1,
    op_other      = 2'd2,
    op_time       = 2'd3
  } host_op_t;

  // merge fsm states
  // st_ack releases the source word after all its copies left
  typedef enum logic [2:0] {
    st_idle   = 3'd0,
    st_time   = 3'd1,
    st_global = 3'd2,
    st_tag    = 3'd3,
    st_other  = 3'd4,
    st_ack    = 3'd5
  } merge_state_t;

endpackage

// File: hdl/bd_word_decoder.sv
`timescale 1ns/1ps

module bd_word_decoder import bd_word_pkg::*; (
  input  logic                clk,
  input  logic                rst_n,
  input  logic                chunk_v,
  output logic                chunk_a,
  input  logic [nchunk-1:0]   chunk,
  output logic                word_v,
  input  logic                word_a,
  output leaf_code_t          leaf_code,
  output logic [npayload-1:0] payload,
  output logic                framing_error
);

  // second chunk carries the low payload bits, first chunk the rest
  localparam int nlo = nchunk - 2;
  localparam int nhi = npayload - nlo;

  logic           take;
  logic           is_first;
  logic           is_second;
  logic           load_word;
  logic           word_v_nxt;
  logic           first_v;
  leaf_code_t     first_leaf;
  logic [nhi-1:0] first_hi;

  assign take = chunk_v & chunk_a;
  assign is_first = chunk[nchunk-1];
  assign is_second = ~chunk[nchunk-1] & ~chunk[nchunk-2];

  // a word is complete when a proper second chunk follows a held first one
  assign load_word = take & is_second & first_v;
  assign word_v_nxt = load_word | (word_v & ~word_a);

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      chunk_a <= 1'b0;
      word_v <= 1'b0;
      first_v <= 1'b0;
      framing_error <= 1'b0;
    end else begin
      // no new chunks while a decoded word waits downstream
      chunk_a <= ~word_v_nxt;
      word_v <= word_v_nxt;
      if (take && is_first) begin
        // a first chunk on top of another one replaces it
        first_v <= 1'b1;
        if (first_v) framing_error <= 1'b1;
      end else if (take) begin
        first_v <= 1'b0;
        if (!load_word) framing_error <= 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (take && is_first) begin
      first_leaf <= leaf_code_t'(chunk[nchunk-2 -: nleaf]);
      first_hi <= chunk[nhi-1:0];
    end
    if (load_word) begin
      leaf_code <= first_leaf;
      payload <= {first_hi, chunk[nlo-1:0]};
    end
  end

  // held word must not change under back-pressure from the splitter
  a_word_hold : assert property (@(posedge clk) disable iff (!rst_n)
    word_v && !word_a |=> word_v && $stable(leaf_code) && $stable(payload));

endmodule

// File: hdl/bd_tag_split.sv
`timescale 1ns/1ps

module bd_tag_split import bd_word_pkg::*; #(
  parameter int unsigned go_home_rt = 255
) (
  input  logic                word_v,
  output logic                word_a,
  input  leaf_code_t          leaf_code,
  input  logic [npayload-1:0] payload,
  input  logic                report_tags,
  output logic                gtag_v,
  input  logic                gtag_a,
  output logic [nglobal-1:0]  gtag_route,
  output logic [ntag-1:0]     gtag_tag,
  output logic [nct-1:0]      gtag_ct,
  output logic                tag_v,
  input  logic                tag_a,
  output logic [ntag-1:0]     tag_tag,
  output logic [nct-1:0]      tag_ct,
  output logic                other_v,
  input  logic                other_a,
  output leaf_code_t          other_leaf_code,
  output logic [npayload-1:0] other_payload
);

  logic [nglobal-1:0] route;
  logic               is_tag;
  logic               to_global;
  logic               to_tag;
  logic               to_other;

  assign route = payload[npayload-1 -: nglobal];

  // readout leaves are the only ones carrying tags
  assign is_tag = (leaf_code == leaf_ro_acc) || (leaf_code == leaf_ro_tat);

  // tags not bound for home leave through the global route
  assign to_global = word_v & is_tag & (route != nglobal'(go_home_rt));
  assign to_tag = word_v & is_tag & ~to_global;

  // home tags are mirrored to other only when reporting is on
  assign to_other = word_v & ~to_global & (~is_tag | report_tags);

  assign gtag_v = to_global;
  assign {gtag_route, gtag_tag, gtag_ct} = payload;

  assign tag_v = to_tag;
  assign tag_tag = payload[ntag+nct-1:nct];
  assign tag_ct = payload[nct-1:0];

  assign other_v = to_other;
  assign other_leaf_code = leaf_code;
  assign other_payload = payload;

  // word is released only once every destination took it
  always_comb begin
    if (to_global) begin
      word_a = gtag_a;
    end else if (to_tag && to_other) begin
      word_a = tag_a & other_a;
    end else if (to_tag) begin
      word_a = tag_a;
    end else if (to_other) begin
      word_a = other_a;
    end else begin
      word_a = 1'b0;
    end
  end

endmodule

// File: hdl/time_unit_timer.sv
`timescale 1ns/1ps

module time_unit_timer #(
  parameter int unsigned time_unit_cycles = 200
) (
  input  logic        clk,
  input  logic        rst_n,
  output logic        time_v,
  input  logic        time_a,
  output logic [15:0] time_count
);

  localparam int ncyc = (time_unit_cycles > 2) ? $clog2(time_unit_cycles) : 1;

  logic [ncyc-1:0] cyc;
  logic            wrap;

  // last cycle of the current time unit
  assign wrap = (cyc == ncyc'(time_unit_cycles - 1));

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      cyc <= '0;
      time_count <= '0;
      time_v <= 1'b0;
    end else begin
      if (wrap) begin
        cyc <= '0;
      end else begin
        cyc <= cyc + 1'b1;
      end

      // count keeps running even when the marker is not taken yet
      if (wrap) begin
        time_count <= time_count + 16'd1;
      end

      // a wrap in the ack cycle keeps the marker pending
      if (wrap) begin
        time_v <= 1'b1;
      end else if (time_a) begin
        time_v <= 1'b0;
      end
    end
  end

endmodule

// File: hdl/upstream_merge_fsm.sv
`timescale 1ns/1ps

module upstream_merge_fsm import host_stream_pkg::*, bd_word_pkg::*; (
  input  logic                  clk,
  input  logic                  rst_n,
  input  logic                  time_v,
  output logic                  time_a,
  input  logic [15:0]           time_count,
  input  logic                  gtag_v,
  output logic                  gtag_a,
  input  logic [nglobal-1:0]    gtag_route,
  input  logic [ntag-1:0]       gtag_tag,
  input  logic [nct-1:0]        gtag_ct,
  input  logic                  tag_v,
  output logic                  tag_a,
  input  logic [ntag-1:0]       tag_tag,
  input  logic [nct-1:0]        tag_ct,
  input  logic                  other_v,
  output logic                  other_a,
  input  leaf_code_t            other_leaf_code,
  input  logic [npayload-1:0]   other_payload,
  output logic                  host_v,
  input  logic                  host_a,
  output host_op_t              host_op,
  output logic [nhost_data-1:0] host_data
);

  merge_state_t state;
  merge_state_t state_nxt;
  logic         done;
  logic         load_time;
  logic         load_gtag;
  logic         load_tag;
  logic         load_other;
  logic         pend_gtag;
  logic         pend_tag;
  logic         pend_other;

  assign done = host_v & host_a;

  always_comb begin
    state_nxt = state;
    load_time = 1'b0;
    load_gtag = 1'b0;
    load_tag = 1'b0;
    load_other = 1'b0;
    case (state)
      st_idle: begin
        // time markers go first, core words wait in the splitter
        if (time_v) begin
          load_time = 1'b1;
          state_nxt = st_time;
        end else if (gtag_v) begin
          load_gtag = 1'b1;
          state_nxt = st_global;
        end else if (tag_v) begin
          load_tag = 1'b1;
          state_nxt = st_tag;
        end else if (other_v) begin
          load_other = 1'b1;
          state_nxt = st_other;
        end
      end
      st_time: if (done) state_nxt = st_idle;
      st_global: if (done) state_nxt = st_ack;
      st_tag: begin
        if (done && pend_other) begin
          // reported home tag, send the mirrored copy right behind
          load_other = 1'b1;
          state_nxt = st_other;
        end else if (done) begin
          state_nxt = st_ack;
        end
      end
      st_other: if (done) state_nxt = st_ack;
      st_ack: state_nxt = st_idle;
      default: state_nxt = st_idle;
    endcase
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state <= st_idle;
      host_v <= 1'b0;
      pend_gtag <= 1'b0;
      pend_tag <= 1'b0;
      pend_other <= 1'b0;
    end else begin
      state <= state_nxt;
      if (load_time || load_gtag || load_tag || load_other) begin
        host_v <= 1'b1;
      end else if (done) begin
        host_v <= 1'b0;
      end
      // remember which split copies must be acked together
      if (load_gtag) pend_gtag <= 1'b1;
      if (load_tag) begin
        pend_tag <= 1'b1;
        pend_other <= other_v;
      end
      if (load_other) pend_other <= 1'b1;
      if (state == st_ack) begin
        pend_gtag <= 1'b0;
        pend_tag <= 1'b0;
        pend_other <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (load_time) begin
      host_op <= op_time;
      host_data <= nhost_data'(time_count);
    end
    if (load_gtag) begin
      host_op <= op_global_tag;
      host_data <= nhost_data'({gtag_route, gtag_tag, gtag_ct});
    end
    if (load_tag) begin
      host_op <= op_tag;
      host_data <= nhost_data'({tag_tag, tag_ct});
    end
    if (load_other) begin
      host_op <= op_other;
      host_data <= nhost_data'({other_leaf_code, other_payload});
    end
  end

  assign time_a = (state == st_time) & done;
  assign gtag_a = (state == st_ack) & pend_gtag;
  assign tag_a = (state == st_ack) & pend_tag;
  assign other_a = (state == st_ack) & pend_other;

  // splitter must never route one word both to global and to home
  a_split_excl : assert property (@(posedge clk) disable iff (!rst_n)
    !(gtag_v && tag_v));

  a_host_hold : assert property (@(posedge clk) disable iff (!rst_n)
    host_v && !host_a |=> host_v && $stable(host_op) && $stable(host_data));

  // st_ack acks exactly the copies the splitter still offers
  a_src_ack : assert property (@(posedge clk) disable iff (!rst_n)
    (gtag_a || tag_a || other_a) |->
      state == st_ack && gtag_a == gtag_v && tag_a == tag_v && other_a == other_v);

  // a marker is only taken while the timer still offers it
  a_time_ack : assert property (@(posedge clk) disable iff (!rst_n)
    time_a |-> state == st_time && time_v && host_op == op_time);

endmodule

// File: hdl/bd_upstream_top.sv
`timescale 1ns/1ps

module bd_upstream_top import bd_word_pkg::*, host_stream_pkg::*; #(
  parameter int unsigned go_home_rt = 255,
  parameter int unsigned time_unit_cycles = 200
) (
  input  logic                  clk,
  input  logic                  rst_n,
  input  logic                  chunk_v,
  output logic                  chunk_a,
  input  logic [nchunk-1:0]     chunk,
  input  logic                  report_tags,
  output logic                  host_v,
  input  logic                  host_a,
  output host_op_t              host_op,
  output logic [nhost_data-1:0] host_data,
  output logic                  framing_error
);

  // decoded word channel
  logic                word_v;
  logic                word_a;
  leaf_code_t          leaf_code;
  logic [npayload-1:0] payload;

  // split channels
  logic                gtag_v;
  logic                gtag_a;
  logic [nglobal-1:0]  gtag_route;
  logic [ntag-1:0]     gtag_tag;
  logic [nct-1:0]      gtag_ct;
  logic                tag_v;
  logic                tag_a;
  logic [ntag-1:0]     tag_tag;
  logic [nct-1:0]      tag_ct;
  logic                other_v;
  logic                other_a;
  leaf_code_t          other_leaf_code;
  logic [npayload-1:0] other_payload;

  // time markers
  logic                time_v;
  logic                time_a;
  logic [15:0]         time_count;

  bd_word_decoder i_decoder (
    .clk(clk), .rst_n(rst_n),
    .chunk_v(chunk_v), .chunk_a(chunk_a), .chunk(chunk),
    .word_v(word_v), .word_a(word_a), .leaf_code(leaf_code), .payload(payload),
    .framing_error(framing_error)
  );

  bd_tag_split #(.go_home_rt(go_home_rt)) i_split (
    .word_v(word_v), .word_a(word_a), .leaf_code(leaf_code), .payload(payload),
    .report_tags(report_tags),
    .gtag_v(gtag_v), .gtag_a(gtag_a), .gtag_route(gtag_route), .gtag_tag(gtag_tag),
    .gtag_ct(gtag_ct),
    .tag_v(tag_v), .tag_a(tag_a), .tag_tag(tag_tag), .tag_ct(tag_ct),
    .other_v(other_v), .other_a(other_a), .other_leaf_code(other_leaf_code),
    .other_payload(other_payload)
  );

  time_unit_timer #(.time_unit_cycles(time_unit_cycles)) i_timer (
    .clk(clk), .rst_n(rst_n),
    .time_v(time_v), .time_a(time_a), .time_count(time_count)
  );

  upstream_merge_fsm i_merge (
    .clk(clk), .rst_n(rst_n),
    .time_v(time_v), .time_a(time_a), .time_count(time_count),
    .gtag_v(gtag_v), .gtag_a(gtag_a), .gtag_route(gtag_route), .gtag_tag(gtag_tag),
    .gtag_ct(gtag_ct),
    .tag_v(tag_v), .tag_a(tag_a), .tag_tag(tag_tag), .tag_ct(tag_ct),
    .other_v(other_v), .other_a(other_a), .other_leaf_code(other_leaf_code),
    .other_payload(other_payload),
    .host_v(host_v), .host_a(host_a), .host_op(host_op), .host_data(host_data)
  );

endmodule

// File: tests/tb_bd_upstream.sv
`timescale 1ns/1ps

module tb_bd_upstream import bd_word_pkg::*, host_stream_pkg::*;;

  localparam int max_wait = 1000;

  logic                  clk;
  logic                  rst_n;
  logic                  chunk_v;
  logic                  chunk_a;
  logic [nchunk-1:0]     chunk;
  logic                  report_tags;
  logic                  host_v;
  logic                  host_a;
  host_op_t              host_op;
  logic [nhost_data-1:0] host_data;
  logic                  framing_error;

  // expected non-time host words with opcode above data
  // top bit marks a copy that must directly follow the word before it
  logic [42:0]           exp_q[$];
  int                    n_time;
  logic [nhost_data-1:0] last_time;

  // short time unit so that markers show up during the run
  bd_upstream_top #(.go_home_rt(255), .time_unit_cycles(37)) i_dut (
    .clk(clk), .rst_n(rst_n),
    .chunk_v(chunk_v), .chunk_a(chunk_a), .chunk(chunk),
    .report_tags(report_tags),
    .host_v(host_v), .host_a(host_a), .host_op(host_op), .host_data(host_data),
    .framing_error(framing_error)
  );

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  task automatic stop_with_failure(input string why);
    $display("%s", why);
    $display(">>> FAIL");
    $fatal(1, "simulation stopped");
  endtask

  task automatic check_value(input string name, input logic [63:0] got, input logic [63:0] exp);
    if (got !== exp) begin
      stop_with_failure($sformatf("FAILED %s: got 0x%0h, expected 0x%0h", name, got, exp));
    end
  endtask

  // called right after a rising edge, returns on the edge that takes the chunk
  task automatic send_chunk(input logic [nchunk-1:0] value);
    int waited;
    waited = 0;
    chunk_v <= 1'b1;
    chunk <= value;
    @(negedge clk);
    while (!chunk_a) begin
      if (waited > max_wait) stop_with_failure("timeout: DUT did not accept a chunk");
      waited++;
      @(negedge clk);
    end
    @(posedge clk);
  endtask

  task automatic run_line(input logic rt, input logic [nchunk-1:0] c1,
                          input logic [nchunk-1:0] c2, input logic err);
    int waited;
    waited = 0;
    // report_tags may only change once the previous word has left the splitter
    while (!chunk_a) begin
      if (waited > max_wait) stop_with_failure("timeout: decoded word never left the decoder");
      waited++;
      @(negedge clk);
    end
    @(posedge clk);
    report_tags <= rt;
    send_chunk(c1);
    send_chunk(c2);
    chunk_v <= 1'b0;
    @(negedge clk);
    check_value("framing_error", 64'(framing_error), 64'(err));
  endtask

  // random back-pressure, host_a low on about a third of the cycles
  initial begin
    void'($urandom(32'hf5150cd5));
    host_a = 1'b0;
    forever begin
      @(posedge clk);
      host_a <= rst_n && (($urandom % 3) != 0);
    end
  end

  // host word monitor, a transfer happens on the next rising edge
  initial begin
    logic [42:0] exp_word;
    logic        last_was_time;
    n_time = 0;
    last_time = '0;
    last_was_time = 1'b0;
    forever begin
      @(negedge clk);
      if (rst_n && host_v && host_a) begin
        if (host_op == op_time) begin
          if (host_data <= last_time) begin
            stop_with_failure($sformatf("FAILED host_data: time count 0x%0h not above 0x%0h",
                                        host_data, last_time));
          end
          last_time = host_data;
          n_time++;
          last_was_time = 1'b1;
        end else if (exp_q.size() == 0) begin
          stop_with_failure("host word arrived while no word was expected");
        end else begin
          exp_word = exp_q.pop_front();
          if (exp_word[42] && last_was_time) begin
            stop_with_failure("time marker came between a home tag and its reported copy");
          end
          check_value("host_op", 64'(host_op), 64'(exp_word[41:40]));
          check_value("host_data", 64'(host_data), 64'(exp_word[39:0]));
          last_was_time = 1'b0;
        end
      end
    end
  end

  initial begin
    int          fd;
    int          n_fields;
    int          n_lines;
    int          waited;
    string       text;
    logic [63:0] rt, c1, c2, err, n, op0, d0, op1, d1;
    rst_n = 1'b0;
    chunk_v = 1'b0;
    chunk = '0;
    report_tags = 1'b0;
    n_lines = 0;
    fd = $fopen("tests/bd_upstream_input.txt", "r");
    if (fd == 0) stop_with_failure("cannot open tests/bd_upstream_input.txt");
    repeat (5) @(posedge clk);
    rst_n <= 1'b1;
    @(negedge clk);
    while ($fgets(text, fd) != 0) begin
      if (text.len() < 2 || text.getc(0) == "#") continue;
      n_fields = $sscanf(text, "%h %h %h %h %h %h %h %h %h",
                         rt, c1, c2, err, n, op0, d0, op1, d1);
      if (n_fields != 9) stop_with_failure($sformatf("malformed vector line: %s", text));
      if (n > 0) exp_q.push_back({1'b0, op0[1:0], d0[39:0]});
      if (n > 1) exp_q.push_back({1'b1, op1[1:0], d1[39:0]});
      run_line(rt[0], c1[nchunk-1:0], c2[nchunk-1:0], err[0]);
      n_lines++;
    end
    $fclose(fd);

    waited = 0;
    while (exp_q.size() != 0) begin
      if (waited > max_wait) begin
        stop_with_failure($sformatf("timeout: %0d host words never arrived", exp_q.size()));
      end
      waited++;
      @(negedge clk);
    end
    waited = 0;
    while (n_time < 2) begin
      if (waited > max_wait) stop_with_failure("timeout: fewer than two time markers arrived");
      waited++;
      @(negedge clk);
    end

    if (n_lines == 0) begin
      stop_with_failure("no vectors were read from the input file");
    end else begin
      $display(">>> PASS");
      $finish;
    end
  end

endmodule

// File: tests/bd_upstream_input.txt
# report_tags chunk1 chunk2 framing_error nwords op0 data0 op1 data1
# all hex, ops 0 global tag 1 tag 2 other, unused pairs are zero
0 AC48D 1565A 0 1 0 001235565A 0 0
0 B03FC 00203 0 1 1 0000000203 0 0
1 AC3FD 3E1C4 0 2 1 000007E1C4 2 0B0FF7E1C4
1 AB7AB 1BEEF 0 1 2 0ADEADBEEF 0 0
1 12345 00001 1 0 0 0000000000 0 0
0 C44D5 39BDF 1 1 2 1113579BDF 0 0
0 B3FFC 12345 1 1 0 00FFF12345 0 0
0 AC3FC 00000 1 1 1 0000000000 0 0
0 83FFF 3FFFF 1 1 2 00FFFFFFFF 0 0
1 AC3F8 00001 1 1 0 000FE00001 0 0
1 B03FF 3FFFF 1 2 1 00000FFFFF 2 0C0FFFFFFF
1 FC000 00001 1 1 2 1F00000001 0 0
0 A2000 00000 1 1 2 0880000000 0 0

// File: sources.f
hdl/bd_word_pkg.sv
hdl/host_stream_pkg.sv
hdl/bd_word_decoder.sv
hdl/bd_tag_split.sv
hdl/time_unit_timer.sv
hdl/upstream_merge_fsm.sv
hdl/bd_upstream_top.sv
tests/tb_bd_upstream.sv

// File: Makefile
SRCS := $(wildcard hdl/*.sv tests/*.sv)

.PHONY: all run clean

all: run

obj_dir/Vtb_bd_upstream: sources.f $(SRCS)
	verilator --binary --timing --assert -f sources.f --top-module tb_bd_upstream -o Vtb_bd_upstream

run: obj_dir/Vtb_bd_upstream tests/bd_upstream_input.txt
	./obj_dir/Vtb_bd_upstream > sim.log 2>&1 || true
	cat sim.log
	if grep -q '>>> FAIL' sim.log; then exit 1; fi
	grep -q '>>> PASS' sim.log

clean:
	rm -rf obj_dir sim.log
